// File: include/tlb_cfg.svh
`ifndef TLB_CFG_SVH
`define TLB_CFG_SVH

// Address space
`define TLB_VA_WIDTH      32
`define TLB_PA_WIDTH      40
`define TLB_PAGE_BITS     12   // 4 KiB pages

// Organisation of the entry banks
`define TLB_N_SETS        8
`define TLB_N_OFFSETS     4    // Offsets swept per set
`define TLB_N_BANKS       4    // Banks compared in parallel

// Configuration write port
`define TLB_WDATA_WIDTH   64
`define TLB_WADDR_WIDTH   8

// Write address map
// Bit 7 low  -> entry bank write, bits 1:0 bank, bits 6:2 entry index
// Bit 7 high -> page store write, bits 6:0 page index
`define TLB_WADDR_PA_BIT  7

`endif

// File: logic/tlb_ctrl_pkg.sv
`default_nettype none

`include "tlb_cfg.svh"

package tlb_ctrl_pkg;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SEARCH,       // Sweeping the offsets of one set
      ST_PA_READ,      // Page number read in flight
      ST_WAIT_WRITE,   // Page store busy with a write
      ST_SEND          // Result held until accepted
   } lookup_state_e;

   typedef logic [$clog2(`TLB_N_OFFSETS)-1:0] offset_t;
   typedef logic [$clog2(`TLB_N_SETS)-1:0]    set_t;
   typedef logic [$clog2(`TLB_N_BANKS)-1:0]   bank_t;

   // Entry index is {set, offset}
   typedef logic [$bits(set_t)+$bits(offset_t)-1:0] entry_idx_t;

   // Page store index is {entry index, bank}
   typedef logic [$bits(entry_idx_t)+$bits(bank_t)-1:0] pa_idx_t;

endpackage

`default_nettype wire

// File: logic/tlb_entry_pkg.sv
`default_nettype none

`include "tlb_cfg.svh"

package tlb_entry_pkg;

   // Page numbers on both sides of the translation
   typedef logic [`TLB_VA_WIDTH-`TLB_PAGE_BITS-1:0] vpn_t;
   typedef logic [`TLB_PA_WIDTH-`TLB_PAGE_BITS-1:0] ppn_t;

   // Kind of access the requester wants to make
   typedef enum logic {
      ACC_READ  = 1'b0,
      ACC_WRITE = 1'b1
   } access_e;

   // Entry word holds the flags in the low bits and the tag above them
   localparam int unsigned ENTRY_V_BIT   = 0;   // Entry valid
   localparam int unsigned ENTRY_R_BIT   = 1;   // Read allowed
   localparam int unsigned ENTRY_W_BIT   = 2;   // Write allowed
   localparam int unsigned ENTRY_TAG_LSB = 3;

   typedef logic [ENTRY_TAG_LSB+$bits(vpn_t)-1:0] entry_word_t;

endpackage

`default_nettype wire

// File: logic/tlb_hit_select.sv
`default_nettype none

`include "tlb_cfg.svh"

module tlb_hit_select (
   input  logic [`TLB_N_BANKS-1:0]                     hit_i,
   input  logic [`TLB_N_BANKS-1:0]                     prot_i,
   input  tlb_ctrl_pkg::entry_idx_t [`TLB_N_BANKS-1:0] entry_idx_i,
   output logic                                        any_hit_o,
   output logic                                        any_prot_o,
   output logic                                        multi_o,
   output tlb_ctrl_pkg::bank_t                         hit_bank_o,
   output tlb_ctrl_pkg::pa_idx_t                       pa_idx_o
);
   import tlb_ctrl_pkg::*;

   logic [$clog2(`TLB_N_BANKS+1)-1:0] n_hits;

   // Walk down so the lowest hitting bank wins
   always_comb begin
      hit_bank_o = '0;
      n_hits     = '0;
      for (int i = `TLB_N_BANKS - 1; i >= 0; i--) begin
         if (hit_i[i]) begin
            hit_bank_o = bank_t'(i);
            n_hits     = n_hits + 1'b1;
         end
      end
   end

   assign any_hit_o  = |hit_i;
   assign any_prot_o = |prot_i;
   assign multi_o    = (n_hits > 1);   // Same page mapped twice at one offset

   // Page store slot of the selected entry
   assign pa_idx_o = {entry_idx_i[hit_bank_o], hit_bank_o};

endmodule

`default_nettype wire

// File: logic/tlb_lookup_fsm.sv
`default_nettype none

`include "tlb_cfg.svh"

module tlb_lookup_fsm (
   input  logic                    clk_i,
   input  logic                    rst_ni,
   input  logic                    start_i,
   input  logic [`TLB_N_BANKS-1:0] bank_we_i,
   input  logic                    pa_wr_i,
   input  logic                    last_i,
   input  logic                    any_hit_i,
   input  logic                    any_prot_i,
   input  logic                    multi_i,
   input  logic                    out_ready_i,
   output logic                    busy_o,
   output logic                    search_en_o,
   output logic                    search_start_o,
   output logic                    pa_rd_en_o,
   output logic                    out_valid_o,
   output logic                    hit_o,
   output logic                    miss_o,
   output logic                    prot_o,
   output logic                    multi_o
);
   import tlb_ctrl_pkg::*;

   lookup_state_e state_q, state_d;
   logic          res_valid_q;     // Bank outputs belong to a real step
   logic          res_last_q;      // ... and that step was the last offset
   logic          last_issued_q;
   logic          hit_d, miss_d, prot_d, multi_d;

   assign busy_o         = (state_q != ST_IDLE);
   assign out_valid_o    = (state_q == ST_SEND);
   assign search_start_o = (state_q == ST_IDLE) && start_i;

   // Any bank write holds the sweep for that cycle
   assign search_en_o = (state_q == ST_SEARCH) && !(|bank_we_i) && !last_issued_q;

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         res_valid_q   <= 1'b0;
         res_last_q    <= 1'b0;
         last_issued_q <= 1'b0;
      end else begin
         res_valid_q <= search_en_o;
         res_last_q  <= last_i;
         if (search_start_o) begin
            last_issued_q <= 1'b0;
         end else if (last_i) begin
            last_issued_q <= 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // Sequencing and outcome
   ////////////////////////////////////////
   always_comb begin
      state_d    = state_q;
      hit_d      = hit_o;
      miss_d     = miss_o;
      prot_d     = prot_o;
      multi_d    = multi_o;
      pa_rd_en_o = 1'b0;

      unique case (state_q)
         ST_IDLE: begin
            if (start_i) state_d = ST_SEARCH;
         end
         ST_SEARCH: begin
            if (res_valid_q) begin
               if (multi_i) begin            // Two banks agree on one tag
                  hit_d   = 1'b1;
                  multi_d = 1'b1;
                  state_d = ST_SEND;
               end else if (any_prot_i) begin
                  hit_d   = 1'b1;
                  prot_d  = 1'b1;
                  state_d = ST_SEND;
               end else if (any_hit_i) begin
                  hit_d      = 1'b1;
                  pa_rd_en_o = 1'b1;
                  state_d    = pa_wr_i ? ST_WAIT_WRITE : ST_PA_READ;
               end else if (res_last_q) begin
                  miss_d  = 1'b1;
                  state_d = ST_SEND;
               end
            end
         end
         ST_PA_READ: state_d = ST_SEND;   // Page number lands in the store register
         ST_WAIT_WRITE: begin
            // Retry from the index held in the page store
            if (!pa_wr_i) begin
               pa_rd_en_o = 1'b1;
               state_d    = ST_SEND;
            end
         end
         ST_SEND: begin
            if (out_ready_i) begin
               hit_d   = 1'b0;
               miss_d  = 1'b0;
               prot_d  = 1'b0;
               multi_d = 1'b0;
               state_d = ST_IDLE;
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q <= ST_IDLE;
         hit_o   <= 1'b0;
         miss_o  <= 1'b0;
         prot_o  <= 1'b0;
         multi_o <= 1'b0;
      end else begin
         state_q <= state_d;
         hit_o   <= hit_d;
         miss_o  <= miss_d;
         prot_o  <= prot_d;
         multi_o <= multi_d;
      end
   end

   // Result and flags hold under back-pressure
   a_result_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
      out_valid_o && !out_ready_i |=>
         out_valid_o && $stable({hit_o, miss_o, prot_o, multi_o}));

endmodule

`default_nettype wire

// File: logic/tlb_offset_counter.sv
`default_nettype none

`include "tlb_cfg.svh"

module tlb_offset_counter (
   input  logic                  clk_i,
   input  logic                  rst_ni,
   input  logic                  search_start_i,
   input  logic                  search_en_i,
   output tlb_ctrl_pkg::offset_t rd_offset_o,
   output logic                  last_o
);
   import tlb_ctrl_pkg::*;

   localparam offset_t LAST_OFFSET = offset_t'(`TLB_N_OFFSETS - 1);

   offset_t offset_q;

   // Every sweep starts at offset 0 of the set
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         offset_q <= '0;
      end else if (search_start_i) begin
         offset_q <= '0;
      end else if (search_en_i) begin
         offset_q <= offset_q + 1'b1;   // One step per enabled cycle
      end
   end

   assign rd_offset_o = offset_q;

   // High in the cycle that issues the final offset
   assign last_o = search_en_i && (offset_q == LAST_OFFSET);

   // The sweep never wraps back to offset 0
   a_no_wrap: assert property (@(posedge clk_i) disable iff (!rst_ni)
      last_o |=> !search_en_i);

endmodule

`default_nettype wire

// File: logic/tlb_pa_store.sv
`default_nettype none

`include "tlb_cfg.svh"

module tlb_pa_store (
   input  logic                        clk_i,
   input  logic                        rst_ni,
   input  logic                        we_i,
   input  logic [`TLB_WADDR_WIDTH-1:0] waddr_i,
   input  logic [`TLB_WDATA_WIDTH-1:0] wdata_i,
   input  logic                        pa_rd_en_i,
   input  tlb_ctrl_pkg::pa_idx_t       pa_idx_i,
   input  logic [`TLB_VA_WIDTH-1:0]    in_addr_i,
   output logic                        pa_wr_o,
   output logic [`TLB_PA_WIDTH-1:0]    out_addr_o
);
   import tlb_entry_pkg::*;
   import tlb_ctrl_pkg::*;

   localparam int unsigned N_PAGES = 2 ** $bits(pa_idx_t);

   ppn_t    mem [N_PAGES];
   pa_idx_t idx_q;
   pa_idx_t rd_idx;
   ppn_t    ppn_q;
   logic    pend_q;     // Read was blocked by a write

   assign pa_wr_o = we_i && waddr_i[`TLB_WADDR_PA_BIT];

   always_ff @(posedge clk_i) begin
      if (pa_wr_o) mem[waddr_i[$bits(pa_idx_t)-1:0]] <= wdata_i[$bits(ppn_t)-1:0];
   end

   // A blocked read is retried from the latched index
   assign rd_idx = pend_q ? idx_q : pa_idx_i;

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         pend_q <= 1'b0;
      end else if (pa_rd_en_i) begin
         pend_q <= pa_wr_o;
      end
   end

   always_ff @(posedge clk_i) begin
      if (pa_rd_en_i) begin
         idx_q <= rd_idx;
         if (!pa_wr_o) ppn_q <= mem[rd_idx];   // Held until the next read
      end
   end

   // Page offset passes straight through
   assign out_addr_o = {ppn_q, in_addr_i[`TLB_PAGE_BITS-1:0]};

endmodule

`default_nettype wire

// File: logic/tlb_top.sv
`default_nettype none

`include "tlb_cfg.svh"

module tlb_top (
   input  logic                        clk_i,
   input  logic                        rst_ni,
   // Configuration writes
   input  logic                        we_i,
   input  logic [`TLB_WADDR_WIDTH-1:0] waddr_i,
   input  logic [`TLB_WDATA_WIDTH-1:0] wdata_i,
   // Request
   input  logic                        start_i,
   output logic                        busy_o,
   input  logic [`TLB_VA_WIDTH-1:0]    in_addr_i,
   input  tlb_entry_pkg::access_e      rw_type_i,
   // Result
   output logic                        out_valid_o,
   input  logic                        out_ready_i,
   output logic                        hit_o,
   output logic                        miss_o,
   output logic                        prot_o,
   output logic                        multi_o,
   output logic [`TLB_PA_WIDTH-1:0]    out_addr_o
);
   import tlb_ctrl_pkg::*;

   logic                          search_en;
   logic                          search_start;
   offset_t                       rd_offset;
   logic                          last;
   logic [`TLB_N_BANKS-1:0]       bank_we;
   logic [`TLB_N_BANKS-1:0]       bank_hit;
   logic [`TLB_N_BANKS-1:0]       bank_prot;
   entry_idx_t [`TLB_N_BANKS-1:0] entry_idx;
   logic                          any_hit, any_prot, multi;
   pa_idx_t                       pa_idx;
   logic                          pa_rd_en;
   logic                          pa_wr;

   ////////////////////////////////////////
   // Control
   ////////////////////////////////////////
   tlb_lookup_fsm u_fsm (
      .clk_i          ( clk_i        ),
      .rst_ni         ( rst_ni       ),
      .start_i        ( start_i      ),
      .bank_we_i      ( bank_we      ),
      .pa_wr_i        ( pa_wr        ),
      .last_i         ( last         ),
      .any_hit_i      ( any_hit      ),
      .any_prot_i     ( any_prot     ),
      .multi_i        ( multi        ),
      .out_ready_i    ( out_ready_i  ),
      .busy_o         ( busy_o       ),
      .search_en_o    ( search_en    ),
      .search_start_o ( search_start ),
      .pa_rd_en_o     ( pa_rd_en     ),
      .out_valid_o    ( out_valid_o  ),
      .hit_o          ( hit_o        ),
      .miss_o         ( miss_o       ),
      .prot_o         ( prot_o       ),
      .multi_o        ( multi_o      )
   );

   tlb_offset_counter u_offset (
      .clk_i          ( clk_i        ),
      .rst_ni         ( rst_ni       ),
      .search_start_i ( search_start ),
      .search_en_i    ( search_en    ),
      .rd_offset_o    ( rd_offset    ),
      .last_o         ( last         )
   );

   ////////////////////////////////////////
   // Entry banks
   ////////////////////////////////////////
   for (genvar b = 0; b < `TLB_N_BANKS; b++) begin : g_bank
      tlb_va_bank #(
         .BANK_IDX ( b )
      ) u_bank (
         .clk_i       ( clk_i        ),
         .rst_ni      ( rst_ni       ),
         .we_i        ( we_i         ),
         .waddr_i     ( waddr_i      ),
         .wdata_i     ( wdata_i      ),
         .in_addr_i   ( in_addr_i    ),
         .rw_type_i   ( rw_type_i    ),
         .rd_offset_i ( rd_offset    ),
         .bank_we_o   ( bank_we[b]   ),
         .hit_o       ( bank_hit[b]  ),
         .prot_o      ( bank_prot[b] ),
         .entry_idx_o ( entry_idx[b] )
      );
   end

   tlb_hit_select u_hit_sel (
      .hit_i       ( bank_hit  ),
      .prot_i      ( bank_prot ),
      .entry_idx_i ( entry_idx ),
      .any_hit_o   ( any_hit   ),
      .any_prot_o  ( any_prot  ),
      .multi_o     ( multi     ),
      .hit_bank_o  (           ),   // Already folded into pa_idx
      .pa_idx_o    ( pa_idx    )
   );

   tlb_pa_store u_pa_store (
      .clk_i      ( clk_i      ),
      .rst_ni     ( rst_ni     ),
      .we_i       ( we_i       ),
      .waddr_i    ( waddr_i    ),
      .wdata_i    ( wdata_i    ),
      .pa_rd_en_i ( pa_rd_en   ),
      .pa_idx_i   ( pa_idx     ),
      .in_addr_i  ( in_addr_i  ),
      .pa_wr_o    ( pa_wr      ),
      .out_addr_o ( out_addr_o )
   );

endmodule

`default_nettype wire

// File: logic/tlb_va_bank.sv
`default_nettype none

`include "tlb_cfg.svh"

module tlb_va_bank #(
   parameter int unsigned BANK_IDX = 0
) (
   input  logic                        clk_i,
   input  logic                        rst_ni,
   input  logic                        we_i,
   input  logic [`TLB_WADDR_WIDTH-1:0] waddr_i,
   input  logic [`TLB_WDATA_WIDTH-1:0] wdata_i,
   input  logic [`TLB_VA_WIDTH-1:0]    in_addr_i,
   input  tlb_entry_pkg::access_e      rw_type_i,
   input  tlb_ctrl_pkg::offset_t       rd_offset_i,
   output logic                        bank_we_o,
   output logic                        hit_o,
   output logic                        prot_o,
   output tlb_ctrl_pkg::entry_idx_t    entry_idx_o
);
   import tlb_entry_pkg::*;
   import tlb_ctrl_pkg::*;

   localparam int unsigned N_ENTRIES = `TLB_N_SETS * `TLB_N_OFFSETS;
   localparam int unsigned BANK_W    = $bits(bank_t);

   entry_word_t mem [N_ENTRIES];
   entry_idx_t  wr_idx;
   entry_idx_t  rd_idx;
   entry_idx_t  idx_q;
   set_t        req_set;
   vpn_t        req_vpn;
   entry_word_t rd_word;
   logic        match;
   logic        perm_ok;
   logic        hit_q, prot_q;

   ////////////////////////////////////////
   // Write decode
   ////////////////////////////////////////
   assign bank_we_o = we_i && !waddr_i[`TLB_WADDR_PA_BIT] &&
                      (waddr_i[BANK_W-1:0] == bank_t'(BANK_IDX));
   assign wr_idx    = waddr_i[BANK_W +: $bits(entry_idx_t)];

   always_ff @(posedge clk_i) begin
      if (bank_we_o) mem[wr_idx] <= wdata_i[$bits(entry_word_t)-1:0];
   end

   ////////////////////////////////////////
   // Read and compare
   ////////////////////////////////////////
   assign req_set = in_addr_i[`TLB_PAGE_BITS +: $bits(set_t)];
   assign req_vpn = in_addr_i[`TLB_VA_WIDTH-1:`TLB_PAGE_BITS];
   assign rd_idx  = {req_set, rd_offset_i};
   assign rd_word = mem[rd_idx];

   assign match   = rd_word[ENTRY_V_BIT] &&
                    (rd_word[ENTRY_TAG_LSB +: $bits(vpn_t)] == req_vpn);
   assign perm_ok = (rw_type_i == ACC_WRITE) ? rd_word[ENTRY_W_BIT] : rd_word[ENTRY_R_BIT];

   // A write cycle issues no read so the last result stays
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         hit_q  <= 1'b0;
         prot_q <= 1'b0;
      end else if (!bank_we_o) begin
         hit_q  <= match;
         prot_q <= match && !perm_ok;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!bank_we_o) idx_q <= rd_idx;
   end

   assign hit_o       = hit_q;
   assign prot_o      = prot_q;
   assign entry_idx_o = idx_q;

endmodule

`default_nettype wire

// File: tlb.f
+incdir+include
logic/tlb_entry_pkg.sv
logic/tlb_ctrl_pkg.sv
logic/tlb_lookup_fsm.sv
logic/tlb_offset_counter.sv
logic/tlb_va_bank.sv
logic/tlb_hit_select.sv
logic/tlb_pa_store.sv
logic/tlb_top.sv
verification/tlb_tb.sv

// File: verification/tlb_tb.sv
`default_nettype none

`include "tlb_cfg.svh"

module tlb_tb;
   import tlb_entry_pkg::*;

   localparam int WAIT_LIMIT = 64;   // Cycles allowed for any single wait

   // Outcome codes, {multi, prot, miss, hit}
   localparam logic [3:0] FLAGS_HIT   = 4'b0001;
   localparam logic [3:0] FLAGS_MISS  = 4'b0010;
   localparam logic [3:0] FLAGS_PROT  = 4'b0101;
   localparam logic [3:0] FLAGS_MULTI = 4'b1001;

   logic                        clk;
   logic                        rst_n;
   logic                        we;
   logic [`TLB_WADDR_WIDTH-1:0] waddr;
   logic [`TLB_WDATA_WIDTH-1:0] wdata;
   logic                        start;
   logic                        busy;
   logic [`TLB_VA_WIDTH-1:0]    in_addr;
   access_e                     rw_type;
   logic                        out_valid;
   logic                        out_ready;
   logic                        hit, miss, prot, multi;
   logic [`TLB_PA_WIDTH-1:0]    out_addr;

   // Mirror of both memories indexed by waddr[6:0]
   logic [22:0] entry_mem [128];
   logic [27:0] page_mem  [128];

   logic [31:0] lfsr_state;
   int          n_issued;
   int          n_checked;
   logic [3:0]  exp_flags;
   logic [39:0] exp_addr;

   tlb_top dut_i (
      .clk_i       ( clk       ),
      .rst_ni      ( rst_n     ),
      .we_i        ( we        ),
      .waddr_i     ( waddr     ),
      .wdata_i     ( wdata     ),
      .start_i     ( start     ),
      .busy_o      ( busy      ),
      .in_addr_i   ( in_addr   ),
      .rw_type_i   ( rw_type   ),
      .out_valid_o ( out_valid ),
      .out_ready_i ( out_ready ),
      .hit_o       ( hit       ),
      .miss_o      ( miss      ),
      .prot_o      ( prot      ),
      .multi_o     ( multi     ),
      .out_addr_o  ( out_addr  )
   );

   always #4 clk = ~clk;

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////
   function automatic logic lfsr_step();
      logic out_bit;
      out_bit    = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) lfsr_state = lfsr_state ^ 32'h8020_0003;   // x^32+x^22+x^2+x+1
      return out_bit;
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) val = {val[30:0], lfsr_step()};
      return val;
   endfunction

   // First offset with any matching valid entry decides the outcome
   function automatic logic [3:0] ref_lookup(input logic [31:0] va, input logic wr_acc,
                                             output logic [39:0] pa);
      logic [19:0] vpn;
      logic [2:0]  set;
      logic [22:0] word;
      int          n_match;
      int          first_bank;
      logic        allowed;
      vpn = va[31:12];
      set = va[14:12];
      pa  = '0;
      for (int off = 0; off < 4; off++) begin
         n_match    = 0;
         first_bank = 0;
         for (int b = 3; b >= 0; b--) begin
            word = entry_mem[{set, 2'(off), 2'(b)}];
            if (word[0] && word[22:3] == vpn) begin
               n_match++;
               first_bank = b;
            end
         end
         if (n_match > 1) return FLAGS_MULTI;
         if (n_match == 1) begin
            word    = entry_mem[{set, 2'(off), 2'(first_bank)}];
            allowed = wr_acc ? word[2] : word[1];
            if (!allowed) return FLAGS_PROT;
            pa = {page_mem[{set, 2'(off), 2'(first_bank)}], va[11:0]};
            return FLAGS_HIT;
         end
      end
      return FLAGS_MISS;
   endfunction

   task automatic abort_run();
      $display("tests failed");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("** Error at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
         abort_run();
      end
   endtask

   // All driving tasks start and end 1 unit after a rising edge
   task automatic write_word(input logic [7:0] addr, input logic [63:0] data);
      we    = 1'b1;
      waddr = addr;
      wdata = data;
      if (addr[7]) page_mem[addr[6:0]] = data[27:0];
      else entry_mem[addr[6:0]] = data[22:0];
      @(posedge clk);
      #1;
      we = 1'b0;
   endtask

   task automatic map_entry(input logic [2:0] set, input logic [1:0] off, input logic [1:0] bank,
                            input logic [19:0] tag, input logic r, input logic w,
                            input logic [27:0] ppn);
      write_word({1'b0, set, off, bank}, 64'({tag, w, r, 1'b1}));
      write_word({1'b1, set, off, bank}, 64'(ppn));
   endtask

   task automatic start_lookup(input logic [31:0] addr, input access_e rw);
      start   = 1'b1;
      in_addr = addr;
      rw_type = rw;
      n_issued++;
      @(posedge clk);
      #1;
      start = 1'b0;
   endtask

   task automatic finish_lookup(input int hold);
      int waited;
      waited = 0;
      while (n_checked != n_issued) begin
         @(posedge clk);
         #1;
         waited++;
         if (waited > WAIT_LIMIT) begin
            $display("Timed out waiting for the lookup result to be checked");
            abort_run();
         end
      end
      repeat (hold) begin
         check_value("out_valid_o while held", out_valid, 1);
         check_value("busy_o while held", busy, 1);
         check_value("flags while held", {multi, prot, miss, hit}, exp_flags);
         if (exp_flags == FLAGS_HIT) check_value("out_addr_o while held", out_addr, exp_addr);
         @(posedge clk);
         #1;
      end
      out_ready = 1'b1;
      @(posedge clk);
      #1;
      out_ready = 1'b0;
      check_value("busy_o after handshake", busy, 0);
      check_value("out_valid_o after handshake", out_valid, 0);
   endtask

   task automatic lookup(input logic [31:0] addr, input access_e rw, input int hold);
      start_lookup(addr, rw);
      finish_lookup(hold);
   endtask

   ////////////////////////////////////////
   // Result checker
   ////////////////////////////////////////
   always begin : compare_results
      int waited;
      @(negedge clk);
      if (n_checked != n_issued) begin
         waited = 0;
         while (!out_valid) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
               $display("Timed out waiting for out_valid_o");
               abort_run();
            end
         end
         exp_flags = ref_lookup(in_addr, rw_type, exp_addr);
         check_value("result flags", {multi, prot, miss, hit}, exp_flags);
         if (exp_flags == FLAGS_HIT) check_value("out_addr_o", out_addr, exp_addr);
         n_checked++;
      end
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////
   initial begin : stimulus
      logic [2:0]  set;
      logic [1:0]  off;
      logic [1:0]  bank;
      logic [19:0] tag;
      logic [31:0] rnd;
      logic [27:0] ppn;
      logic [11:0] page_off;
      clk        = 1'b0;
      rst_n      = 1'b0;
      we         = 1'b0;
      waddr      = '0;
      wdata      = '0;
      start      = 1'b0;
      in_addr    = '0;
      rw_type    = ACC_READ;
      out_ready  = 1'b0;
      lfsr_state = 32'hb6fa;
      n_issued   = 0;
      n_checked  = 0;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_value("outputs after reset", {busy, out_valid, multi, prot, miss, hit}, 6'b0);

      for (int i = 0; i < 128; i++) write_word(8'(i), 64'd0);   // All entries invalid

      // Random hits across sets, offsets and banks
      for (int i = 0; i < 12; i++) begin
         set      = 3'(random_bits(3));
         off      = 2'(random_bits(2));
         bank     = 2'(random_bits(2));
         rnd      = random_bits(17);
         tag      = {rnd[16:0], set};
         ppn      = 28'(random_bits(28));
         page_off = 12'(random_bits(12));
         map_entry(set, off, bank, tag, 1'b1, 1'b1, ppn);
         lookup({tag, page_off}, access_e'(lfsr_step()), 0);
      end

      // Unmapped pages
      for (int i = 0; i < 4; i++) begin
         rnd = random_bits(32);
         lookup(rnd, ACC_READ, 0);
      end

      // Read-only entry
      rnd = random_bits(17);
      tag = {rnd[16:0], 3'd2};
      map_entry(3'd2, 2'd1, 2'd3, tag, 1'b1, 1'b0, 28'(random_bits(28)));
      lookup({tag, 12'h5a4}, ACC_WRITE, 0);
      lookup({tag, 12'h5a4}, ACC_READ, 0);

      // Same tag in two banks of one offset
      rnd = random_bits(17);
      tag = {rnd[16:0], 3'd5};
      map_entry(3'd5, 2'd2, 2'd0, tag, 1'b1, 1'b1, 28'(random_bits(28)));
      map_entry(3'd5, 2'd2, 2'd2, tag, 1'b1, 1'b1, 28'(random_bits(28)));
      lookup({tag, 12'h010}, ACC_READ, 0);

      // Back-pressure with bank and page writes to other sets in flight
      rnd = random_bits(17);
      tag = {rnd[16:0], 3'd6};
      map_entry(3'd6, 2'd3, 2'd1, tag, 1'b1, 1'b1, 28'(random_bits(28)));
      start_lookup({tag, 12'hfed}, ACC_READ);
      write_word({1'b0, 3'd1, 2'd0, 2'd2}, random_bits(32));
      write_word({1'b0, 3'd1, 2'd3, 2'd1}, random_bits(32));
      write_word({1'b1, 3'd0, 2'd1, 2'd1}, random_bits(28));
      finish_lookup(6);

      // Page writes around the hit force the wait on the page store
      rnd = random_bits(17);
      tag = {rnd[16:0], 3'd4};
      map_entry(3'd4, 2'd0, 2'd2, tag, 1'b1, 1'b1, 28'(random_bits(28)));
      start_lookup({tag, 12'h321}, ACC_WRITE);
      for (int i = 0; i < 3; i++) write_word({1'b1, 3'd3, 2'(i), 2'd0}, random_bits(28));
      finish_lookup(4);

      if (n_checked != n_issued) begin
         $display("Not every lookup result was checked");
         abort_run();
      end else begin
         $display("all tests passed");
         $finish;
      end
   end

endmodule

`default_nettype wire
